// File: adc_stats_pkg.sv
package adc_stats_pkg;

    ////////////////////////////////////////
    // ADC code
    ////////////////////////////////////////

    // Converter resolution
    localparam int SAMPLE_W = 12;

    // Raw unsigned converter code
    typedef logic [SAMPLE_W-1:0] sample_t;

    ////////////////////////////////////////
    // Millivolt values
    ////////////////////////////////////////

    // Enough for references up to 65.5 V
    localparam int MV_W = 16;

    // Unsigned millivolt value
    typedef logic [MV_W-1:0] mv_t;

    ////////////////////////////////////////
    // Accumulation
    ////////////////////////////////////////

    // Window sum, 4096 full-scale samples max
    localparam int ACC_W = 24;

endpackage

// File: sample_window.sv
`timescale 1ns/1ps

module sample_window
    import adc_stats_pkg::*;
#(
    parameter int SAMPLES = 80
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    sample_valid,
    input  sample_t sample,
    output logic    win_valid,
    output sample_t win_sample,
    output logic    win_first,
    output logic    win_last
);

    ////////////////////////////////////////
    // Position counter
    ////////////////////////////////////////

    // At least one bit, even for one-sample windows
    localparam int POS_W = (SAMPLES > 1) ? $clog2(SAMPLES) : 1;

    // Index of the closing sample
    localparam logic [POS_W-1:0] LAST_POS = POS_W'(SAMPLES - 1);

    // Position of the next strobed sample in its window
    logic [POS_W-1:0] pos;

    // Boundary flags for the sample arriving now
    logic at_first;
    logic at_last;

    assign at_first = (pos == '0);
    assign at_last  = (pos == LAST_POS);

    always_ff @(posedge clk) begin
        if (rst) begin
            pos       <= '0;
            win_valid <= 1'b0;
            win_first <= 1'b0;
            win_last  <= 1'b0;
        end else begin
            // One cycle of latency from the strobe
            win_valid <= sample_valid;
            if (sample_valid) begin
                win_first <= at_first;
                win_last  <= at_last;
                // Advance on strobes only, wrap at the window end
                pos <= at_last ? '0 : pos + 1'b1;
            end
        end
    end

    // Sample data travels alongside the strobe
    always_ff @(posedge clk) begin
        if (sample_valid) begin
            win_sample <= sample;
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // A multi-sample window never opens and closes on one sample
    first_last_excl: assert property (@(posedge clk) disable iff (rst)
        !((SAMPLES > 1) && win_valid && win_first && win_last))
        else $error("win_first and win_last high together");

endmodule

// File: window_stats.sv
`timescale 1ns/1ps

module window_stats
    import adc_stats_pkg::*;
#(
    parameter int SAMPLES = 80
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    win_valid,
    input  sample_t win_sample,
    input  logic    win_first,
    input  logic    win_last,
    output logic    stats_valid,
    output sample_t avg_code,
    output sample_t min_code,
    output sample_t max_code
);

    // Window length at accumulator width
    localparam logic [ACC_W-1:0] DIVISOR = ACC_W'(SAMPLES);

    ////////////////////////////////////////
    // Running statistics
    ////////////////////////////////////////

    // State over the samples seen so far in this window
    logic [ACC_W-1:0] sum_acc;
    sample_t          min_acc;
    sample_t          max_acc;

    // State with the current sample folded in
    logic [ACC_W-1:0] sum_nxt;
    sample_t          min_nxt;
    sample_t          max_nxt;

    // Truncated mean of the finished window
    logic [ACC_W-1:0] avg_full;

    always_comb begin
        if (win_first) begin
            // New window seeds from its own first sample
            sum_nxt = ACC_W'(win_sample);
            min_nxt = win_sample;
            max_nxt = win_sample;
        end else begin
            sum_nxt = sum_acc + ACC_W'(win_sample);
            min_nxt = (win_sample < min_acc) ? win_sample : min_acc;
            max_nxt = (win_sample > max_acc) ? win_sample : max_acc;
        end
    end

    // Constant divisor, mean of 12-bit codes stays below 4096
    assign avg_full = sum_nxt / DIVISOR;

    // Accumulate on every valid sample
    always_ff @(posedge clk) begin
        if (win_valid) begin
            sum_acc <= sum_nxt;
            min_acc <= min_nxt;
            max_acc <= max_nxt;
        end
    end

    ////////////////////////////////////////
    // Result registers
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            stats_valid <= 1'b0;
            avg_code    <= '0;
            min_code    <= '0;
            max_code    <= '0;
        end else begin
            // Pulse one cycle after the closing sample
            stats_valid <= win_valid && win_last;
            if (win_valid && win_last) begin
                // Codes hold until the next window closes
                avg_code <= sample_t'(avg_full);
                min_code <= min_nxt;
                max_code <= max_nxt;
            end
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // Windows are never shorter than two strobes apart
    stats_pulse: assert property (@(posedge clk) disable iff (rst)
        (SAMPLES > 1) && stats_valid |=> !stats_valid)
        else $error("stats_valid longer than one cycle");

    // Mean lies between the extremes of the same window
    stats_order: assert property (@(posedge clk) disable iff (rst)
        stats_valid |-> (min_code <= avg_code) && (avg_code <= max_code))
        else $error("min/avg/max out of order");

endmodule

// File: code_to_millivolts.sv
`timescale 1ns/1ps

module code_to_millivolts
    import adc_stats_pkg::*;
#(
    parameter int VREF_MV = 3300
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    stats_valid,
    input  sample_t avg_code,
    input  sample_t min_code,
    input  sample_t max_code,
    output logic    result_valid,
    output mv_t     avg_mv,
    output mv_t     min_mv,
    output mv_t     max_mv
);

    ////////////////////////////////////////
    // Scaling
    ////////////////////////////////////////

    // Full scale is 2^SAMPLE_W codes
    localparam int FRAC_W = SAMPLE_W;
    localparam int PROD_W = FRAC_W + MV_W;

    // Reference voltage at product width
    localparam logic [PROD_W-1:0] VREF = PROD_W'(VREF_MV);

    // Code times reference, fraction bits dropped
    function automatic mv_t to_mv(input sample_t code);
        logic [PROD_W-1:0] prod;
        prod = PROD_W'(code) * VREF;
        return prod[PROD_W-1:FRAC_W];
    endfunction

    ////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
            avg_mv       <= '0;
            min_mv       <= '0;
            max_mv       <= '0;
        end else begin
            result_valid <= stats_valid;
            // Convert on the statistics pulse only
            if (stats_valid) begin
                avg_mv <= to_mv(avg_code);
                min_mv <= to_mv(min_code);
                max_mv <= to_mv(max_code);
            end
        end
    end

    // Exactly one cycle of latency through this stage
    result_follows: assert property (@(posedge clk) disable iff (rst)
        result_valid == $past(stats_valid))
        else $error("result_valid does not track stats_valid");

endmodule

// File: adc_stats_top.sv
`timescale 1ns/1ps

module adc_stats_top
    import adc_stats_pkg::*;
#(
    parameter int SAMPLES = 80,
    parameter int VREF_MV = 3300
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    sample_valid,
    input  sample_t sample,
    output logic    result_valid,
    output sample_t avg_code,
    output sample_t min_code,
    output sample_t max_code,
    output mv_t     avg_mv,
    output mv_t     min_mv,
    output mv_t     max_mv
);

    // Framing to statistics
    logic    win_valid;
    sample_t win_sample;
    logic    win_first;
    logic    win_last;

    // Statistics to scaling
    logic    stats_valid;

    ////////////////////////////////////////
    // Pipeline, three cycles end to end
    ////////////////////////////////////////

    sample_window #(
        .SAMPLES (SAMPLES)
    ) sample_window_i (
        .clk          (clk),
        .rst          (rst),
        .sample_valid (sample_valid),
        .sample       (sample),
        .win_valid    (win_valid),
        .win_sample   (win_sample),
        .win_first    (win_first),
        .win_last     (win_last)
    );

    // Raw codes also leave the top directly
    window_stats #(
        .SAMPLES (SAMPLES)
    ) window_stats_i (
        .clk         (clk),
        .rst         (rst),
        .win_valid   (win_valid),
        .win_sample  (win_sample),
        .win_first   (win_first),
        .win_last    (win_last),
        .stats_valid (stats_valid),
        .avg_code    (avg_code),
        .min_code    (min_code),
        .max_code    (max_code)
    );

    code_to_millivolts #(
        .VREF_MV (VREF_MV)
    ) code_to_millivolts_i (
        .clk          (clk),
        .rst          (rst),
        .stats_valid  (stats_valid),
        .avg_code     (avg_code),
        .min_code     (min_code),
        .max_code     (max_code),
        .result_valid (result_valid),
        .avg_mv       (avg_mv),
        .min_mv       (min_mv),
        .max_mv       (max_mv)
    );

endmodule

// File: tb_adc_stats.sv
`timescale 1ns/1ps

module tb_adc_stats
    import adc_stats_pkg::*;
();

    localparam int SAMPLES       = 16;
    localparam int VREF_MV       = 3300;
    localparam int NUM_WIN       = 3;
    // Samples plus expected avg, min, max
    localparam int WORDS_PER_WIN = SAMPLES + 3;
    localparam int TOTAL_WORDS   = NUM_WIN * WORDS_PER_WIN;
    // Watchdog budget from the sample count
    localparam int TIMEOUT_CYCLES = NUM_WIN * SAMPLES * 5 + 100;

    logic    clk;
    logic    rst;
    logic    sample_valid;
    sample_t sample;
    logic    result_valid;
    sample_t avg_code;
    sample_t min_code;
    sample_t max_code;
    mv_t     avg_mv;
    mv_t     min_mv;
    mv_t     max_mv;

    // Stimulus and expected codes from the data file
    sample_t tdata [0:TOTAL_WORDS-1];

    // Outstanding windows, due cycle and index
    int unsigned exp_due [$];
    int          exp_win [$];
    int          results_seen = 0;
    int unsigned cycle = 0;
    logic [31:0] rng_state = 32'd96;

    adc_stats_top #(
        .SAMPLES (SAMPLES),
        .VREF_MV (VREF_MV)
    ) adc_stats_top_i (
        .clk          (clk),
        .rst          (rst),
        .sample_valid (sample_valid),
        .sample       (sample),
        .result_valid (result_valid),
        .avg_code     (avg_code),
        .min_code     (min_code),
        .max_code     (max_code),
        .avg_mv       (avg_mv),
        .min_mv       (min_mv),
        .max_mv       (max_mv)
    );

    ////////////////////////////////////////
    // Clock and cycle count
    ////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Cycle index, read mid-cycle only
    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    // xorshift32 step
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Code times reference over full scale, truncated
    function automatic mv_t mv_from_code(input sample_t code);
        int unsigned scaled;
        scaled = int'(code) * VREF_MV;
        return mv_t'(scaled / 4096);
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_code(input string name, input sample_t got, input sample_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR at %0t ns: %s is %0d, expected %0d",
                $time, name, got, exp));
        end
    endtask

    task automatic check_mv(input string name, input mv_t got, input mv_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR at %0t ns: %s is %0d mV, expected %0d mV",
                $time, name, got, exp));
        end
    endtask

    task automatic check_cycle(input string name, input int unsigned got,
                               input int unsigned exp);
        if (got != exp) begin
            abort_run($sformatf("ERROR at %0t ns: %s is cycle %0d, expected cycle %0d",
                $time, name, got, exp));
        end
    endtask

    // Compare all six outputs against one window's expected codes
    task automatic check_window(input int win);
        int      base;
        sample_t exp_avg;
        sample_t exp_min;
        sample_t exp_max;
        base    = win * WORDS_PER_WIN + SAMPLES;
        exp_avg = tdata[base];
        exp_min = tdata[base + 1];
        exp_max = tdata[base + 2];
        check_code("avg_code", avg_code, exp_avg);
        check_code("min_code", min_code, exp_min);
        check_code("max_code", max_code, exp_max);
        check_mv("avg_mv", avg_mv, mv_from_code(exp_avg));
        check_mv("min_mv", min_mv, mv_from_code(exp_min));
        check_mv("max_mv", max_mv, mv_from_code(exp_max));
    endtask

    ////////////////////////////////////////
    // Result monitor
    ////////////////////////////////////////

    // Falling edge, outputs settled
    always @(negedge clk) begin
        if (!rst) begin
            if (result_valid) begin
                // Pulse with nothing outstanding is a stray
                if (exp_due.size() == 0) begin
                    abort_run("result_valid pulsed while no window was outstanding");
                end
                check_cycle("result_valid", cycle, exp_due[0]);
                check_window(exp_win[0]);
                void'(exp_due.pop_front());
                void'(exp_win.pop_front());
                results_seen = results_seen + 1;
            end else if (exp_due.size() != 0 && cycle > exp_due[0]) begin
                abort_run($sformatf("The result of window %0d never arrived", exp_win[0]));
            end
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    initial begin
        int gap;
        rst          = 1'b1;
        sample_valid = 1'b0;
        sample       = '0;
        $readmemh("adc_stats_testdata.txt", tdata);
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        // Idle after reset, everything reads zero
        repeat (4) begin
            @(negedge clk);
            check_code("avg_code", avg_code, '0);
            check_code("min_code", min_code, '0);
            check_code("max_code", max_code, '0);
            check_mv("avg_mv", avg_mv, '0);
            check_mv("min_mv", min_mv, '0);
            check_mv("max_mv", max_mv, '0);
        end
        @(posedge clk);
        #1;
        for (int w = 0; w < NUM_WIN; w++) begin
            for (int s = 0; s < SAMPLES; s++) begin
                // No idle cycle across window boundaries
                if (w > 0 && s == 0) begin
                    gap = 0;
                end else begin
                    gap = next_random() % 4;
                end
                repeat (gap) begin
                    @(posedge clk);
                    #1;
                end
                sample_valid = 1'b1;
                sample       = tdata[w * WORDS_PER_WIN + s];
                // Last sample sets the three-cycle deadline
                if (s == SAMPLES - 1) begin
                    exp_due.push_back(cycle + 3);
                    exp_win.push_back(w);
                end
                @(posedge clk);
                #1;
                sample_valid = 1'b0;
            end
        end
        wait (results_seen == NUM_WIN);
        // Quiet tail to catch extra pulses
        repeat (8) @(posedge clk);
        $display("All tests passed");
        $finish;
    end

    ////////////////////////////////////////
    // Watchdog
    ////////////////////////////////////////

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        abort_run("Watchdog expired before all window results arrived");
    end

endmodule

// File: adc_stats_testdata.txt
// Each window: 16 sample codes, then expected average, min and max codes
// All values are 12-bit hex ADC codes, one per line
// Window 0, constant level
7D0
7D0
7D0
7D0
7D0
7D0
7D0
7D0
7D0
7D0
7D0
7D0
7D0
7D0
7D0
7D0
7D0
7D0
7D0
// Window 1, spans the full range 0 to 4095
000
FFF
800
400
C00
100
200
300
500
600
700
900
A00
B00
D00
E00
78F
000
FFF
// Window 2, rising ramp with a nonzero floor
080
170
260
350
440
530
620
710
800
8F0
9E0
AD0
BC0
CB0
DA0
E90
788
080
E90

// File: build.f
adc_stats_pkg.sv
sample_window.sv
window_stats.sv
code_to_millivolts.sv
adc_stats_top.sv
tb_adc_stats.sv
